// File: mul_pkg.sv
// --------------------------------------------------------------------------
// Shared widths, encodings and message types of the iterative multiply unit
// MUL_CYCLES must divide XLEN evenly (1, 2, 4 or 8 give a clean datapath)
// Only MULx uops are encoded here, division is not part of this unit
// --------------------------------------------------------------------------
package mul_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------

  // Operand and result width
  localparam int XLEN          = 32;
  // In-flight tag width
  localparam int SEQ_NUM_BITS  = 5;
  localparam int REG_ADDR_BITS = 5;

  // Core iteration count and the multiplier bits retired per iteration
  localparam int MUL_CYCLES     = 8;
  localparam int BITS_PER_CYCLE = XLEN / MUL_CYCLES;
  // Counter width, at least one bit even for a single iteration
  localparam int MUL_CNT_BITS   = (MUL_CYCLES > 1) ? $clog2(MUL_CYCLES) : 1;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------

  // MUL, MULH, MULHSU, MULHU
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HUU = 2'd3
  } rv_mul_uop_e;

  // Iterative core FSM
  typedef enum logic [1:0] {
    CORE_IDLE = 2'd0,
    CORE_BUSY = 2'd1,
    CORE_DONE = 2'd2
  } mul_core_state_e;

  // ------------------------------------------------------------------------
  // Messages
  // ------------------------------------------------------------------------

  // Decode to execute, 108 bits
  typedef struct packed {
    logic [XLEN-1:0]          pc;
    logic [SEQ_NUM_BITS-1:0]  seq_num;
    logic [XLEN-1:0]          op1;
    logic [XLEN-1:0]          op2;
    logic [REG_ADDR_BITS-1:0] waddr;
    rv_mul_uop_e              uop;
  } d_x_msg_t;

  // Fields that ride along untouched, 44 bits
  typedef struct packed {
    logic [XLEN-1:0]          pc;
    logic [SEQ_NUM_BITS-1:0]  seq_num;
    logic [REG_ADDR_BITS-1:0] waddr;
    rv_mul_uop_e              uop;
  } mul_tag_t;

  // Unsigned magnitudes plus the sign of the final product
  typedef struct packed {
    mul_tag_t        tag;
    logic [XLEN-1:0] mag1;
    logic [XLEN-1:0] mag2;
    logic            neg_result;
  } prep_msg_t;

  // Full magnitude product, sign not yet applied
  typedef struct packed {
    mul_tag_t          tag;
    logic [2*XLEN-1:0] product;
    logic              neg_result;
  } core_msg_t;

  // Execute to writeback, 75 bits
  typedef struct packed {
    logic [XLEN-1:0]          pc;
    logic [SEQ_NUM_BITS-1:0]  seq_num;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic [XLEN-1:0]          wdata;
    logic                     wen;
  } x_w_msg_t;

endpackage

// File: mul_operand_prep.sv
// --------------------------------------------------------------------------
// Input stage, one register deep
// Operands leave as unsigned magnitudes; the product sign travels alongside
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mul_operand_prep (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                d_val,
  output logic                d_rdy,
  input  mul_pkg::d_x_msg_t   d_msg,
  output logic                prep_val,
  input  logic                prep_rdy,
  output mul_pkg::prep_msg_t  prep_msg
);
  import mul_pkg::*;

  logic      op1_signed;
  logic      op2_signed;
  logic      neg1;
  logic      neg2;
  logic      accept;
  logic      val_q;
  prep_msg_t msg_d;
  prep_msg_t msg_q;

  // Signedness per operand; MUL_LO low word is sign agnostic
  always_comb begin
    op1_signed = 1'b0;
    op2_signed = 1'b0;
    case (d_msg.uop)
      MUL_HSS: begin
        op1_signed = 1'b1;
        op2_signed = 1'b1;
      end
      MUL_HSU: op1_signed = 1'b1;
      default: ;
    endcase
  end

  assign neg1 = op1_signed & d_msg.op1[XLEN-1];
  assign neg2 = op2_signed & d_msg.op2[XLEN-1];

  // Magnitudes; most negative value maps to 2^(XLEN-1) as unsigned
  always_comb begin
    msg_d.tag.pc      = d_msg.pc;
    msg_d.tag.seq_num = d_msg.seq_num;
    msg_d.tag.waddr   = d_msg.waddr;
    msg_d.tag.uop     = d_msg.uop;
    msg_d.mag1        = neg1 ? (~d_msg.op1 + 1'b1) : d_msg.op1;
    msg_d.mag2        = neg2 ? (~d_msg.op2 + 1'b1) : d_msg.op2;
    msg_d.neg_result  = neg1 ^ neg2;
  end

  // Empty, or draining this cycle
  assign d_rdy  = !val_q || prep_rdy;
  assign accept = d_val && d_rdy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      val_q <= 1'b0;
    end else if (accept) begin
      val_q <= 1'b1;
    end else if (prep_rdy) begin
      val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      msg_q <= msg_d;
    end
  end

  assign prep_val = val_q;
  assign prep_msg = msg_q;

endmodule

// File: mul_iterative_core.sv
// --------------------------------------------------------------------------
// Shift-add multiplier on unsigned magnitudes, BITS_PER_CYCLE bits per step
// Exactly MUL_CYCLES busy cycles per multiply; one multiply at a time
// Result held in CORE_DONE until taken
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mul_iterative_core (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                prep_val,
  output logic                prep_rdy,
  input  mul_pkg::prep_msg_t  prep_msg,
  output logic                core_val,
  input  logic                core_rdy,
  output mul_pkg::core_msg_t  core_msg
);
  import mul_pkg::*;

  mul_core_state_e         state_q;
  mul_core_state_e         state_d;
  logic [MUL_CNT_BITS-1:0] count_q;
  logic                    accept;
  logic                    last_iter;

  // Datapath registers
  logic [2*XLEN-1:0]       acc_q;
  logic [2*XLEN-1:0]       mcand_q;
  logic [XLEN-1:0]         mplier_q;
  logic [2*XLEN-1:0]       partial_sum;
  mul_tag_t                tag_q;
  logic                    neg_q;

  // ------------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------------

  // Idle, or result leaving this cycle
  assign prep_rdy  = (state_q == CORE_IDLE) ||
                     ((state_q == CORE_DONE) && core_rdy);
  assign accept    = prep_val && prep_rdy;
  assign last_iter = (count_q == MUL_CNT_BITS'(MUL_CYCLES - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      CORE_IDLE: begin
        if (accept) state_d = CORE_BUSY;
      end
      CORE_BUSY: begin
        if (last_iter) state_d = CORE_DONE;
      end
      CORE_DONE: begin
        // Back-to-back: reload straight into BUSY
        if (accept) begin
          state_d = CORE_BUSY;
        end else if (core_rdy) begin
          state_d = CORE_IDLE;
        end
      end
      default: state_d = CORE_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= CORE_IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        count_q <= '0;
      end else if (state_q == CORE_BUSY) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------------------

  // Partial products of the low multiplier bits
  always_comb begin
    partial_sum = '0;
    for (int b = 0; b < BITS_PER_CYCLE; b++) begin
      if (mplier_q[b]) begin
        partial_sum = partial_sum + (mcand_q << b);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      acc_q    <= '0;
      mcand_q  <= {{XLEN{1'b0}}, prep_msg.mag1};
      mplier_q <= prep_msg.mag2;
      tag_q    <= prep_msg.tag;
      neg_q    <= prep_msg.neg_result;
    end else if (state_q == CORE_BUSY) begin
      acc_q    <= acc_q + partial_sum;
      mcand_q  <= mcand_q << BITS_PER_CYCLE;
      mplier_q <= mplier_q >> BITS_PER_CYCLE;
    end
  end

  assign core_val            = (state_q == CORE_DONE);
  assign core_msg.tag        = tag_q;
  assign core_msg.product    = acc_q;
  assign core_msg.neg_result = neg_q;

endmodule

// File: mul_result_format.sv
// --------------------------------------------------------------------------
// Output stage, one register deep
// Applies the sign to the full product, then picks the low or high word
// Writes to x0 go out with wen low
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mul_result_format (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                core_val,
  output logic                core_rdy,
  input  mul_pkg::core_msg_t  core_msg,
  output logic                w_val,
  input  logic                w_rdy,
  output mul_pkg::x_w_msg_t   w_msg
);
  import mul_pkg::*;

  logic [2*XLEN-1:0] product_signed;
  logic              accept;
  logic              val_q;
  x_w_msg_t          msg_d;
  x_w_msg_t          msg_q;

  // Two's complement of the whole 2*XLEN product
  assign product_signed = core_msg.neg_result ? (~core_msg.product + 1'b1)
                                              : core_msg.product;

  always_comb begin
    msg_d.pc      = core_msg.tag.pc;
    msg_d.seq_num = core_msg.tag.seq_num;
    msg_d.waddr   = core_msg.tag.waddr;
    // MUL takes low word, all MULH variants the high word
    if (core_msg.tag.uop == MUL_LO) begin
      msg_d.wdata = product_signed[XLEN-1:0];
    end else begin
      msg_d.wdata = product_signed[2*XLEN-1:XLEN];
    end
    // x0 is hardwired zero
    msg_d.wen     = (core_msg.tag.waddr != '0);
  end

  // ------------------------------------------------------------------------
  // Pipeline register
  // ------------------------------------------------------------------------

  assign core_rdy = !val_q || w_rdy;
  assign accept   = core_val && core_rdy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      val_q <= 1'b0;
    end else if (accept) begin
      val_q <= 1'b1;
    end else if (w_rdy) begin
      val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      msg_q <= msg_d;
    end
  end

  assign w_val = val_q;
  assign w_msg = msg_q;

endmodule

// File: mul_execute_unit.sv
// --------------------------------------------------------------------------
// Multiply execute unit: prep, iterative core, format
// Up to three multiplies in flight, strictly in order
// Latency MUL_CYCLES+2 from decode accept to w_val with no back-pressure
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mul_execute_unit (
  input  logic               clk,
  input  logic               arst_n,
  // Decode side
  input  logic               d_val,
  output logic               d_rdy,
  input  mul_pkg::d_x_msg_t  d_msg,
  // Writeback side
  output logic               w_val,
  input  logic               w_rdy,
  output mul_pkg::x_w_msg_t  w_msg
);
  import mul_pkg::*;

  // Prep to core
  logic      prep_val;
  logic      prep_rdy;
  prep_msg_t prep_msg;

  // Core to format
  logic      core_val;
  logic      core_rdy;
  core_msg_t core_msg;

  mul_operand_prep u_prep (
    .clk      (clk),
    .arst_n   (arst_n),
    .d_val    (d_val),
    .d_rdy    (d_rdy),
    .d_msg    (d_msg),
    .prep_val (prep_val),
    .prep_rdy (prep_rdy),
    .prep_msg (prep_msg)
  );

  mul_iterative_core u_core (
    .clk      (clk),
    .arst_n   (arst_n),
    .prep_val (prep_val),
    .prep_rdy (prep_rdy),
    .prep_msg (prep_msg),
    .core_val (core_val),
    .core_rdy (core_rdy),
    .core_msg (core_msg)
  );

  mul_result_format u_fmt (
    .clk      (clk),
    .arst_n   (arst_n),
    .core_val (core_val),
    .core_rdy (core_rdy),
    .core_msg (core_msg),
    .w_val    (w_val),
    .w_rdy    (w_rdy),
    .w_msg    (w_msg)
  );

endmodule

// File: mul_execute_unit_sva.sv
// --------------------------------------------------------------------------
// Handshake checks on the ports of the multiply execute unit
// Bound into every mul_execute_unit; stall checks idle while arst_n is low
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mul_execute_unit_sva (
  input logic              clk,
  input logic              arst_n,
  input logic              d_rdy,
  input logic              w_val,
  input logic              w_rdy,
  input mul_pkg::x_w_msg_t w_msg
);

  // Stalled writeback keeps valid and payload
  a_w_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (w_val && !w_rdy) |=> (w_val && $stable(w_msg)))
    else $error("w_val or w_msg changed while stalled");

  // No X on valid once out of reset
  a_w_val_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(w_val))
    else $error("w_val unknown after reset");

  // Input stage empty on the first edge after release
  a_d_rdy_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> d_rdy)
    else $error("d_rdy low in first cycle after reset");

endmodule

bind mul_execute_unit mul_execute_unit_sva u_sva (
  .clk    (clk),
  .arst_n (arst_n),
  .d_rdy  (d_rdy),
  .w_val  (w_val),
  .w_rdy  (w_rdy),
  .w_msg  (w_msg)
);

// File: mul_execute_unit_tb.sv
// --------------------------------------------------------------------------
// Directed testbench for the multiply execute unit
// Expected writebacks come from a 2*XLEN product model and an LFSR seeded 8073
// Inputs change 1 ns after a rising edge; outputs sampled on falling edges
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mul_execute_unit_tb;
  import mul_pkg::*;

  localparam int TOTAL_MSGS      = 178;
  localparam int WATCHDOG_CYCLES = TOTAL_MSGS * (MUL_CYCLES + 2) * 4 + 500;

  logic     clk = 1'b0;
  logic     arst_n;
  logic     d_val;
  logic     d_rdy;
  d_x_msg_t d_msg;
  logic     w_val;
  logic     w_rdy;
  x_w_msg_t w_msg;

  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          err_at_start = 0;
  int          seq_ctr = 0;
  int          last_accept = 0;
  bit          ready_gaps = 1'b0;
  bit          wb_stall = 1'b0;
  string       cur_test = "init";
  // Index 0 for stimulus, index 1 for writeback ready gaps
  logic [15:0] lfsr_state [2] = '{16'd8073, 16'd8073};
  x_w_msg_t    expected_q [$];

  mul_execute_unit i_dut (.*);

  always #5 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Galois LFSR with taps 16 14 13 11 returning the bit shifted out
  function automatic logic lfsr_step(input int src);
    logic out_bit;
    out_bit = lfsr_state[src][0];
    lfsr_state[src] = lfsr_state[src] >> 1;
    if (out_bit) lfsr_state[src] = lfsr_state[src] ^ 16'hB400;
    return out_bit;
  endfunction

  function automatic logic [31:0] rand_bits(input int src, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step(src)};
    return v;
  endfunction

  // Low word is sign agnostic; high word per operand signedness
  function automatic logic [XLEN-1:0] ref_wdata(input rv_mul_uop_e uop,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] a_u;
    logic [2*XLEN-1:0] b_u;
    logic [2*XLEN-1:0] a_s;
    logic [2*XLEN-1:0] b_s;
    logic [2*XLEN-1:0] p;
    a_u = {{XLEN{1'b0}}, a};
    b_u = {{XLEN{1'b0}}, b};
    a_s = {{XLEN{a[XLEN-1]}}, a};
    b_s = {{XLEN{b[XLEN-1]}}, b};
    case (uop)
      MUL_HSS: p = a_s * b_s;
      MUL_HSU: p = a_s * b_u;
      default: p = a_u * b_u;
    endcase
    return (uop == MUL_LO) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
  endfunction

  // Zero, one, all ones, most negative, most positive
  function automatic logic [XLEN-1:0] corner(input int i);
    case (i)
      0:       return '0;
      1:       return XLEN'(1);
      2:       return '1;
      3:       return {1'b1, {(XLEN-1){1'b0}}};
      default: return {1'b0, {(XLEN-1){1'b1}}};
    endcase
  endfunction

  task automatic check_value(input string what, input logic [63:0] want,
                             input logic [63:0] got);
    checks++;
    if (want !== got) begin
      errors++;
      $display("error [%s] %s: expected 0x%0h actual 0x%0h", cur_test, what, want, got);
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_op(input rv_mul_uop_e uop, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [REG_ADDR_BITS-1:0] waddr);
    x_w_msg_t want;
    d_val         = 1'b1;
    d_msg.pc      = XLEN'(32'h1000 + seq_ctr * 4);
    d_msg.seq_num = SEQ_NUM_BITS'(seq_ctr);
    d_msg.op1     = a;
    d_msg.op2     = b;
    d_msg.waddr   = waddr;
    d_msg.uop     = uop;
    seq_ctr++;
    want.pc      = d_msg.pc;
    want.seq_num = d_msg.seq_num;
    want.waddr   = waddr;
    want.wdata   = ref_wdata(uop, a, b);
    want.wen     = (waddr != '0);
    do @(negedge clk); while (!d_rdy);
    // Transfer on the coming edge
    last_accept = cyc + 1;
    expected_q.push_back(want);
    @(posedge clk);
    #1;
    d_val = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (expected_q.size() != 0 && n < 20 * (MUL_CYCLES + 2)) begin
      @(negedge clk);
      n++;
    end
    if (expected_q.size() != 0) begin
      errors++;
      $display("[%s] %0d messages never came back", cur_test, expected_q.size());
      expected_q.delete();
    end
    idle_cycles(1);
  endtask

  function automatic logic [REG_ADDR_BITS-1:0] nonzero_waddr();
    return REG_ADDR_BITS'(rand_bits(0, REG_ADDR_BITS)) | REG_ADDR_BITS'(1);
  endfunction

  // 5x5 corner pairs, then 8 LFSR pairs
  task automatic run_operand_set(input rv_mul_uop_e uop);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send_op(uop, corner(i), corner(j), nonzero_waddr());
      end
    end
    repeat (8) begin
      a = XLEN'(rand_bits(0, XLEN));
      b = XLEN'(rand_bits(0, XLEN));
      send_op(uop, a, b, nonzero_waddr());
    end
  endtask

  task automatic begin_test(input string name);
    cur_test     = name;
    err_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("%-20s %s, %0d errors", cur_test,
             (errors == err_at_start) ? "ok" : "FAILED", errors - err_at_start);
  endtask

  // --------------------------------------------------------------------------
  // Writeback side
  // --------------------------------------------------------------------------

  // Ready gaps about one cycle in four while enabled, low throughout a stall
  initial begin
    w_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      w_rdy = wb_stall ? 1'b0 : (ready_gaps ? (rand_bits(1, 2) != '0) : 1'b1);
    end
  end

  // Transfer seen at the falling edge completes on the next rising edge
  always @(negedge clk) begin
    if (arst_n && w_val && w_rdy) begin
      if (expected_q.size() == 0) begin
        errors++;
        $display("[%s] writeback seen with nothing outstanding", cur_test);
      end else begin
        x_w_msg_t want;
        want = expected_q.pop_front();
        check_value("pc", 64'(want.pc), 64'(w_msg.pc));
        check_value("seq_num", 64'(want.seq_num), 64'(w_msg.seq_num));
        check_value("waddr", 64'(want.waddr), 64'(w_msg.waddr));
        check_value("wdata", 64'(want.wdata), 64'(w_msg.wdata));
        check_value("wen", 64'(want.wen), 64'(w_msg.wen));
      end
    end
  end

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic reset_and_latency();
    int n;
    begin_test("reset_latency");
    @(negedge clk);
    check_value("w_val after reset", 64'd0, 64'(w_val));
    check_value("d_rdy after reset", 64'd1, 64'(d_rdy));
    idle_cycles(1);
    send_op(MUL_LO, 32'd12345, 32'd678, 5'd3);
    n = 0;
    while (!w_val && n < 4 * (MUL_CYCLES + 2)) begin
      @(negedge clk);
      n++;
    end
    check_value("latency", 64'(MUL_CYCLES + 2), 64'(cyc - last_accept));
    wait_drain();
    finish_test();
  endtask

  task automatic low_word_operands();
    begin_test("mul_lo_operands");
    run_operand_set(MUL_LO);
    wait_drain();
    finish_test();
  endtask

  task automatic high_word_variants();
    begin_test("mulh_variants");
    run_operand_set(MUL_HSS);
    run_operand_set(MUL_HSU);
    run_operand_set(MUL_HUU);
    wait_drain();
    finish_test();
  endtask

  // x0 keeps its data but drops the write
  task automatic x0_writes();
    begin_test("x0_writes");
    send_op(MUL_HSS, 32'h8000_0000, 32'hFFFF_FFFF, 5'd0);
    send_op(MUL_LO, 32'hDEAD_BEEF, 32'h0000_0010, 5'd31);
    wait_drain();
    finish_test();
  endtask

  task automatic streaming_backpressure();
    rv_mul_uop_e             uop;
    logic [XLEN-1:0]          a;
    logic [XLEN-1:0]          b;
    logic [REG_ADDR_BITS-1:0] waddr;
    begin_test("streaming");
    @(negedge clk);
    ready_gaps = 1'b1;
    idle_cycles(1);
    for (int k = 0; k < 40; k++) begin
      uop   = rv_mul_uop_e'(2'(rand_bits(0, 2)));
      a     = XLEN'(rand_bits(0, XLEN));
      b     = XLEN'(rand_bits(0, XLEN));
      waddr = REG_ADDR_BITS'(rand_bits(0, REG_ADDR_BITS));
      send_op(uop, a, b, waddr);
      if (rand_bits(0, 1) != '0) idle_cycles(int'(rand_bits(0, 2)));
    end
    wait_drain();
    // Writeback held so prep, core and format all fill up
    @(negedge clk);
    wb_stall = 1'b1;
    idle_cycles(1);
    repeat (3) begin
      uop = rv_mul_uop_e'(2'(rand_bits(0, 2)));
      a   = XLEN'(rand_bits(0, XLEN));
      b   = XLEN'(rand_bits(0, XLEN));
      send_op(uop, a, b, nonzero_waddr());
    end
    idle_cycles(3 * (MUL_CYCLES + 2));
    @(negedge clk);
    check_value("d_rdy with three stages full", 64'd0, 64'(d_rdy));
    wb_stall = 1'b0;
    wait_drain();
    finish_test();
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    arst_n = 1'b0;
    d_val  = 1'b0;
    d_msg  = '0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    reset_and_latency();
    low_word_operands();
    high_word_variants();
    x0_writes();
    streaming_backpressure();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test);
    $display("tests failed");
    $finish;
  end

endmodule

// File: filelist.f
mul_pkg.sv
mul_operand_prep.sv
mul_iterative_core.sv
mul_result_format.sv
mul_execute_unit.sv
mul_execute_unit_sva.sv
mul_execute_unit_tb.sv

// File: Makefile
# Verilator lint and simulation of the multiply execute unit

SIM        := verilator
TOP        := mul_execute_unit_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
PASS_MSG   := all tests passed

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass message stands on a line of its own
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
